// ==== all.f ====
+incdir+hdl
hdl/iot_pkg.sv
hdl/byte_collector.sv
hdl/crc3_engine.sv
hdl/extreme_tracker.sv
hdl/block_processor.sv
hdl/iot_top.sv
dv/iot_tb.sv

// ==== dv/iot_tb.sv ====
`include "iot_config.svh"

module iot_tb;

  import iot_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int WAIT_LIMIT = 500;
  localparam int BLK_BYTES  = `IOT_BLOCK_BYTES;
  localparam int GRP_BLKS   = `IOT_GROUP_BLOCKS;

  logic                   clk;
  logic                   rst;
  logic                   i_in_en;
  logic [`IOT_BYTE_W-1:0] i_iot_in;
  logic [2:0]             i_fn_sel;
  logic                   o_valid;
  block_t                 o_iot_out;

  integer                 seed;
  logic [`IOT_BYTE_W-1:0] tx_q[$];
  block_t                 exp_q[$];
  block_t                 grp[GRP_BLKS];

  iot_top uut (
    .clk       (clk),
    .rst       (rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_block(input string name, input block_t exp, input block_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_crc(input string name, input logic [`IOT_CRC_W-1:0] exp,
                           input logic [`IOT_CRC_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  // long division of the block followed by three zeros, generator 1011
  function automatic logic [`IOT_CRC_W-1:0] crc_model(input block_t blk);
    logic [`IOT_BLOCK_W+2:0] dvd;
    int                      i;
    dvd = {blk, 3'b000};
    for (i = `IOT_BLOCK_W + 2; i >= 3; i--) begin
      if (dvd[i]) begin
        dvd[i -: 4] = dvd[i -: 4] ^ 4'b1011;
      end
    end
    return dvd[2:0];
  endfunction

  function automatic block_t rand_block();
    block_t b;
    int     k;
    for (k = 0; k < `IOT_BLOCK_W / 32; k++) begin
      b[k*32 +: 32] = $random(seed);
    end
    return b;
  endfunction

  // first byte on the wire is the msb of the block
  task automatic queue_block(input block_t blk);
    int k;
    for (k = BLK_BYTES - 1; k >= 0; k--) begin
      tx_q.push_back(blk[k*`IOT_BYTE_W +: `IOT_BYTE_W]);
    end
  endtask

  // bubble sort of the group, best first
  task automatic push_extremes(input bit find_max);
    block_t tmp;
    int     i;
    int     j;
    for (i = 0; i < GRP_BLKS - 1; i++) begin
      for (j = 0; j < GRP_BLKS - 1 - i; j++) begin
        if (find_max ? (grp[j+1] > grp[j]) : (grp[j+1] < grp[j])) begin
          tmp      = grp[j];
          grp[j]   = grp[j+1];
          grp[j+1] = tmp;
        end
      end
    end
    exp_q.push_back(grp[0]);
    exp_q.push_back(grp[1]);
  endtask

  task automatic apply_reset(input fn_e fn);
    @(posedge clk);
    #1;
    rst      = 1'b1;
    i_in_en  = 1'b0;
    i_fn_sel = fn;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // idle cycles after every full block when gap is nonzero
  task automatic drive_bytes(input int gap);
    int n;
    n = 0;
    while (tx_q.size() > 0) begin
      @(posedge clk);
      #1;
      i_in_en  = 1'b1;
      i_iot_in = tx_q.pop_front();
      n++;
      if (gap > 0 && (n % BLK_BYTES) == 0) begin
        @(posedge clk);
        #1;
        i_in_en = 1'b0;
        repeat (gap - 1) @(posedge clk);
      end
    end
    @(posedge clk);
    #1;
    i_in_en = 1'b0;
  endtask

  task automatic wait_valid(input string name);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!o_valid) begin
      cnt++;
      if (cnt >= WAIT_LIMIT) begin
        abort_run($sformatf("%s timed out waiting for a valid output", name));
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (o_valid) begin
        abort_run($sformatf("%s saw a valid output where none was expected", name));
      end
    end
  endtask

  task automatic collect_crc(input string name, input int count);
    block_t exp;
    int     j;
    for (j = 0; j < count; j++) begin
      wait_valid(name);
      exp = exp_q.pop_front();
      check_crc(name, exp[`IOT_CRC_W-1:0], o_iot_out[`IOT_CRC_W-1:0]);
      // upper bits must be zero too
      check_block(name, exp, o_iot_out);
    end
  endtask

  task automatic collect_pairs(input string name, input int groups);
    int g;
    for (g = 0; g < groups; g++) begin
      wait_valid(name);
      check_block(name, exp_q.pop_front(), o_iot_out);
      @(negedge clk);
      if (!o_valid) begin
        abort_run($sformatf("%s lost valid after one cycle of a pair", name));
      end
      check_block(name, exp_q.pop_front(), o_iot_out);
      @(negedge clk);
      if (o_valid) begin
        abort_run($sformatf("%s kept valid longer than two cycles", name));
      end
    end
  endtask

  task automatic test_crc_single();
    block_t blk;
    blk = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    apply_reset(FN_CRC_GEN);
    queue_block(blk);
    exp_q.push_back(block_t'(crc_model(blk)));
    fork
      drive_bytes(0);
      collect_crc("test_crc_single", 1);
    join
    expect_quiet("test_crc_single", 20);
  endtask

  task automatic test_crc_stream();
    block_t blk;
    int     i;
    apply_reset(FN_CRC_GEN);
    for (i = 0; i < 4; i++) begin
      blk = rand_block();
      queue_block(blk);
      exp_q.push_back(block_t'(crc_model(blk)));
    end
    fork
      drive_bytes(0);
      collect_crc("test_crc_stream", 4);
    join
    expect_quiet("test_crc_stream", 20);
  endtask

  task automatic test_top2max();
    int i;
    apply_reset(FN_TOP2MAX);
    for (i = 0; i < GRP_BLKS; i++) begin
      grp[i] = rand_block();
      grp[i][`IOT_BLOCK_W-1] = 1'b0;
    end
    // tie for the largest
    grp[2][`IOT_BLOCK_W-1] = 1'b1;
    grp[6] = grp[2];
    for (i = 0; i < GRP_BLKS; i++) begin
      queue_block(grp[i]);
    end
    push_extremes(1'b1);
    fork
      drive_bytes(0);
      collect_pairs("test_top2max", 1);
    join
  endtask

  task automatic test_last2min();
    int g;
    int i;
    apply_reset(FN_LAST2MIN);
    for (g = 0; g < 2; g++) begin
      for (i = 0; i < GRP_BLKS; i++) begin
        grp[i] = rand_block();
        queue_block(grp[i]);
      end
      push_extremes(1'b0);
    end
    fork
      drive_bytes(3);
      collect_pairs("test_last2min", 2);
    join
  endtask

  task automatic test_unsupported();
    apply_reset(FN_ENCRYPT);
    queue_block(rand_block());
    queue_block(rand_block());
    fork
      drive_bytes(0);
      expect_quiet("test_unsupported", 300);
    join
  endtask

  task automatic test_reset_discard();
    block_t blk;
    apply_reset(FN_CRC_GEN);
    queue_block(rand_block());
    // keep only the first 10 bytes
    repeat (BLK_BYTES - 10) void'(tx_q.pop_back());
    drive_bytes(0);
    apply_reset(FN_CRC_GEN);
    expect_quiet("test_reset_discard", 5);
    blk = rand_block();
    queue_block(blk);
    exp_q.push_back(block_t'(crc_model(blk)));
    fork
      drive_bytes(0);
      collect_crc("test_reset_discard", 1);
    join
    expect_quiet("test_reset_discard", 20);
  endtask

  initial begin
    seed     = 32'hfb9f_93be;
    rst      = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = '0;
    i_fn_sel = FN_NONE;
    test_crc_single();
    test_crc_stream();
    test_top2max();
    test_last2min();
    test_unsupported();
    test_reset_discard();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== hdl/block_processor.sv ====
module block_processor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [2:0]           i_fn_sel,
  input  iot_pkg::byte_beat_t  i_byte,
  input  iot_pkg::block_beat_t i_block,
  output logic                 o_valid,
  output iot_pkg::block_t      o_iot_out
);

  import iot_pkg::*;

  fn_e         fn;
  logic        crc_sel;
  logic        trk_sel;
  logic        find_max;
  byte_beat_t  crc_byte;
  block_beat_t trk_block;
  result_t     crc_res;
  result_t     trk_res;
  result_t     sel_res;

  assign fn = fn_e'(i_fn_sel);

  always_comb begin
    crc_sel  = 1'b0;
    trk_sel  = 1'b0;
    find_max = 1'b0;
    case (fn)
      FN_CRC_GEN: crc_sel = 1'b1;
      FN_TOP2MAX: begin
        trk_sel  = 1'b1;
        find_max = 1'b1;
      end
      FN_LAST2MIN: trk_sel = 1'b1;
      // no cipher in this design
      FN_NONE, FN_ENCRYPT, FN_DECRYPT: ;
      default: ;
    endcase
  end

  // idle engine sees no beats
  always_comb begin
    crc_byte        = i_byte;
    crc_byte.valid  = i_byte.valid & crc_sel;
    trk_block       = i_block;
    trk_block.valid = i_block.valid & trk_sel;
  end

  crc3_engine u_crc (
    .clk      (clk),
    .rst      (rst),
    .i_byte   (crc_byte),
    .o_result (crc_res)
  );

  extreme_tracker u_tracker (
    .clk        (clk),
    .rst        (rst),
    .i_find_max (find_max),
    .i_block    (trk_block),
    .o_result   (trk_res)
  );

  always_comb begin
    sel_res = '0;
    if (crc_sel) begin
      sel_res = crc_res;
    end else if (trk_sel) begin
      sel_res = trk_res;
    end
  end

  assign o_valid   = sel_res.valid;
  assign o_iot_out = sel_res.valid ? sel_res.data : '0;

  // a result may only come from the selected engine
  a_crc_only_when_selected : assert property (
    @(posedge clk) disable iff (rst)
    crc_res.valid |-> crc_sel
  );

  a_trk_only_when_selected : assert property (
    @(posedge clk) disable iff (rst)
    trk_res.valid |-> trk_sel
  );

endmodule

// ==== hdl/byte_collector.sv ====
`include "iot_config.svh"

module byte_collector (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_in_en,
  input  logic [`IOT_BYTE_W-1:0] i_iot_in,
  output iot_pkg::byte_beat_t    o_byte,
  output iot_pkg::block_beat_t   o_block
);

  import iot_pkg::*;

  localparam int CNT_W = $clog2(`IOT_BLOCK_BYTES);

  logic [CNT_W-1:0]       byte_cnt;
  logic                   last_byte;
  logic                   byte_valid_q;
  logic                   byte_last_q;
  logic [`IOT_BYTE_W-1:0] byte_data_q;
  logic                   block_valid_q;
  block_t                 asm_q;

  assign last_byte = (byte_cnt == CNT_W'(`IOT_BLOCK_BYTES - 1));

  // control flops
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byte_cnt      <= '0;
      byte_valid_q  <= 1'b0;
      byte_last_q   <= 1'b0;
      block_valid_q <= 1'b0;
    end else begin
      byte_valid_q  <= i_in_en;
      byte_last_q   <= i_in_en && last_byte;
      block_valid_q <= i_in_en && last_byte;
      if (i_in_en) begin
        byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
      end
    end
  end

  // oldest byte drifts up to the msbs
  always_ff @(posedge clk) begin
    if (i_in_en) begin
      byte_data_q <= i_iot_in;
      asm_q       <= {asm_q[`IOT_BLOCK_W-`IOT_BYTE_W-1:0], i_iot_in};
    end
  end

  assign o_byte.valid  = byte_valid_q;
  assign o_byte.last   = byte_last_q;
  assign o_byte.data   = byte_data_q;

  assign o_block.valid = block_valid_q;
  assign o_block.data  = asm_q;

  // a completed block carries no unknown bits
  a_block_known : assert property (
    @(posedge clk) disable iff (rst)
    o_block.valid |-> !$isunknown(o_block.data)
  );

endmodule

// ==== hdl/crc3_engine.sv ====
`include "iot_config.svh"

module crc3_engine (
  input  logic                clk,
  input  logic                rst,
  input  iot_pkg::byte_beat_t i_byte,
  output iot_pkg::result_t    o_result
);

  import iot_pkg::*;

  logic [`IOT_CRC_W-1:0] rem_q;
  logic [`IOT_CRC_W-1:0] rem_nxt;
  logic [`IOT_CRC_W-1:0] crc_q;
  logic                  res_valid_q;

  // eight bit steps, msb first
  function automatic logic [`IOT_CRC_W-1:0] crc_fold(
    input logic [`IOT_CRC_W-1:0]  rem_in,
    input logic [`IOT_BYTE_W-1:0] data
  );
    logic [`IOT_CRC_W-1:0] rem;
    logic                  fb;
    rem = rem_in;
    for (int i = `IOT_BYTE_W - 1; i >= 0; i--) begin
      fb  = rem[`IOT_CRC_W-1] ^ data[i];
      rem = {rem[`IOT_CRC_W-2:0], 1'b0};
      if (fb) begin
        rem = rem ^ `IOT_CRC_POLY;
      end
    end
    return rem;
  endfunction

  assign rem_nxt = crc_fold(rem_q, i_byte.data);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rem_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= i_byte.valid && i_byte.last;
      // restart from zero for the next block
      if (i_byte.valid) begin
        rem_q <= i_byte.last ? '0 : rem_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_byte.valid && i_byte.last) begin
      crc_q <= rem_nxt;
    end
  end

  assign o_result.valid = res_valid_q;
  assign o_result.data  = block_t'(crc_q);

  // one pulse per block
  a_single_pulse : assert property (
    @(posedge clk) disable iff (rst)
    o_result.valid |=> !o_result.valid
  );

endmodule

// ==== hdl/extreme_tracker.sv ====
`include "iot_config.svh"

module extreme_tracker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_find_max,
  input  iot_pkg::block_beat_t i_block,
  output iot_pkg::result_t     o_result
);

  import iot_pkg::*;

  localparam int CNT_W = $clog2(`IOT_GROUP_BLOCKS);

  track_state_e     state_q;
  track_state_e     state_nxt;
  logic [CNT_W-1:0] blk_cnt;
  logic             group_done;
  block_t           best_q;
  block_t           second_q;
  block_t           best_nxt;
  block_t           second_nxt;
  block_t           emit_best_q;
  block_t           emit_second_q;
  block_t           out_data_q;
  logic             out_valid_q;

  // unsigned and strictly better in the selected direction
  function automatic logic beats(input logic find_max, input block_t a, input block_t b);
    return find_max ? (a > b) : (a < b);
  endfunction

  assign group_done = i_block.valid && (blk_cnt == CNT_W'(`IOT_GROUP_BLOCKS - 1));

  // ranking of the incoming block
  always_comb begin
    best_nxt   = best_q;
    second_nxt = second_q;
    if (blk_cnt == '0) begin
      // first block of a group resets the runner-up to the weakest value
      best_nxt   = i_block.data;
      second_nxt = i_find_max ? '0 : '1;
    end else if (beats(i_find_max, i_block.data, best_q)) begin
      best_nxt   = i_block.data;
      second_nxt = best_q;
    end else if (beats(i_find_max, i_block.data, second_q)) begin
      second_nxt = i_block.data;
    end
  end

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      TRK_COLLECT: begin
        if (group_done) begin
          state_nxt = TRK_EMIT_FIRST;
        end
      end
      TRK_EMIT_FIRST:  state_nxt = TRK_EMIT_SECOND;
      TRK_EMIT_SECOND: state_nxt = TRK_COLLECT;
      default:         state_nxt = TRK_COLLECT;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= TRK_COLLECT;
      blk_cnt     <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q     <= state_nxt;
      out_valid_q <= (state_q == TRK_EMIT_FIRST) || (state_q == TRK_EMIT_SECOND);
      // counting goes on while the previous group drains
      if (i_block.valid) begin
        blk_cnt <= group_done ? '0 : blk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_block.valid) begin
      best_q   <= best_nxt;
      second_q <= second_nxt;
    end
    // snapshot of the finished group
    if (group_done) begin
      emit_best_q   <= best_nxt;
      emit_second_q <= second_nxt;
    end
    if (state_q == TRK_EMIT_FIRST) begin
      out_data_q <= emit_best_q;
    end else if (state_q == TRK_EMIT_SECOND) begin
      out_data_q <= emit_second_q;
    end
  end

  assign o_result.valid = out_valid_q;
  assign o_result.data  = out_data_q;

  // a group must not close while the previous one is being emitted
  a_close_in_collect : assert property (
    @(posedge clk) disable iff (rst)
    group_done |-> (state_q == TRK_COLLECT)
  );

  // best and runner-up follow two cycles after the closing block
  a_two_cycle_valid : assert property (
    @(posedge clk) disable iff (rst)
    group_done |-> ##2 o_result.valid ##1 o_result.valid ##1 !o_result.valid
  );

endmodule

// ==== hdl/iot_config.svh ====
`ifndef IOT_CONFIG_SVH
`define IOT_CONFIG_SVH

// byte stream and block geometry
`define IOT_BYTE_W 8
`define IOT_BLOCK_BYTES 16
`define IOT_BLOCK_W (`IOT_BYTE_W * `IOT_BLOCK_BYTES)

// blocks compared per extreme group
`define IOT_GROUP_BLOCKS 8

// crc-3, generator x^3 + x + 1
`define IOT_CRC_W 3
// low terms only, the x^3 term is implied
`define IOT_CRC_POLY 3'b011

`endif

// ==== hdl/iot_pkg.sv ====
`include "iot_config.svh"

package iot_pkg;

  // function select codes as seen on i_fn_sel
  typedef enum logic [2:0] {
    FN_NONE     = 3'd0,
    FN_ENCRYPT  = 3'd1,
    FN_DECRYPT  = 3'd2,
    FN_CRC_GEN  = 3'd3,
    FN_TOP2MAX  = 3'd4,
    FN_LAST2MIN = 3'd5
  } fn_e;

  // one full block, first byte received in the top bits
  typedef logic [`IOT_BLOCK_W-1:0] block_t;

  // one byte per beat
  typedef struct packed {
    logic                  valid;
    logic                  last;  // completes a block
    logic [`IOT_BYTE_W-1:0] data;
  } byte_beat_t;

  // completed block strobe
  typedef struct packed {
    logic   valid;
    block_t data;
  } block_beat_t;

  // engine result toward the output mux
  typedef struct packed {
    logic   valid;
    block_t data;
  } result_t;

  // extreme tracker FSM
  typedef enum logic [1:0] {
    TRK_COLLECT,
    TRK_EMIT_FIRST,
    TRK_EMIT_SECOND
  } track_state_e;

endpackage

// ==== hdl/iot_top.sv ====
`include "iot_config.svh"

module iot_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_in_en,
  input  logic [`IOT_BYTE_W-1:0] i_iot_in,
  input  logic [2:0]             i_fn_sel,
  output logic                   o_valid,
  output iot_pkg::block_t        o_iot_out
);

  import iot_pkg::*;

  byte_beat_t  byte_beat;
  block_beat_t block_beat;

  // bytes to blocks
  byte_collector u_collector (
    .clk      (clk),
    .rst      (rst),
    .i_in_en  (i_in_en),
    .i_iot_in (i_iot_in),
    .o_byte   (byte_beat),
    .o_block  (block_beat)
  );

  // crc and extreme engines
  block_processor u_processor (
    .clk       (clk),
    .rst       (rst),
    .i_fn_sel  (i_fn_sel),
    .i_byte    (byte_beat),
    .i_block   (block_beat),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

endmodule
